//--- src/sb_settings.svh
`ifndef SB_SETTINGS_SVH
`define SB_SETTINGS_SVH

// window geometry
`define SB_DEPTH 16
`define SB_IDX_W 4

// architectural state
`define SB_NUM_REGS 32
`define SB_XLEN 32

// stall_o rises once occupancy goes above this
`define SB_STALL_LEVEL 12

// issue to writeback, multiplier
`define SB_MUL_LAT 4

`endif

//--- src/sb_pkg.sv
`default_nettype none

`include "sb_settings.svh"

package sb_pkg;

    // bit IDX_W set means no producer
    typedef logic [`SB_IDX_W:0] sb_tag_t;
    localparam sb_tag_t SB_TAG_NULL = {1'b1, {`SB_IDX_W{1'b0}}};

    typedef logic [$clog2(`SB_NUM_REGS)-1:0] sb_reg_t;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } sb_fu_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL
    } sb_op_e;

    typedef struct packed {
        logic [10:0] pad;
        sb_reg_t     rt;
    } sb_src2_reg_t;

    // second operand, register form or immediate depending on use_imm
    typedef union packed {
        sb_src2_reg_t       r;
        logic signed [15:0] imm;
    } sb_src2_u;

    typedef struct packed {
        logic [15:0] id;      // source sequence tag
        sb_fu_e      fu;
        sb_op_e      op;
        sb_reg_t     rd;
        sb_reg_t     rs;
        logic        use_imm;
        sb_src2_u    src2;
    } sb_inst_t;

    typedef struct packed {
        logic     fire;
        sb_tag_t  tag;
        sb_inst_t inst;
    } sb_disp_t;

    typedef struct packed {
        logic               valid;
        sb_tag_t            tag;
        sb_op_e             op;
        logic [`SB_XLEN-1:0] a;
        logic [`SB_XLEN-1:0] b;
    } sb_issue_t;

    typedef struct packed {
        logic               valid;
        sb_tag_t            tag;
        logic [`SB_XLEN-1:0] data;
    } sb_wb_t;

    typedef struct packed {
        logic               valid;
        logic [15:0]        id;
        logic               we;
        sb_reg_t            rd;
        logic [`SB_XLEN-1:0] data;
    } sb_retire_t;

endpackage

`default_nettype wire

//--- src/sb_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_window (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inst_valid_i,
    input  sb_pkg::sb_inst_t         inst_i,
    input  logic [1:0]               fu_busy_i,
    input  logic                     dest_busy_i,
    input  sb_pkg::sb_wb_t           alu_wb_i,
    input  sb_pkg::sb_wb_t           mul_wb_i,
    output logic                     stall_o,
    output sb_pkg::sb_disp_t         disp_o,
    output sb_pkg::sb_retire_t [1:0] retire_o,
    output sb_pkg::sb_tag_t [1:0]    retire_tag_o
);

    localparam int IDX_W = `SB_IDX_W;

    sb_pkg::sb_inst_t    inst_q [`SB_DEPTH];
    logic [`SB_XLEN-1:0] data_q [`SB_DEPTH];
    logic [`SB_DEPTH-1:0] valid_q;
    logic [`SB_DEPTH-1:0] disp_q;
    logic [`SB_DEPTH-1:0] exec_q;

    logic [IDX_W-1:0] wptr_q;
    logic [IDX_W-1:0] dptr_q;
    logic [IDX_W-1:0] rptr_q;
    logic [IDX_W:0]   count_q;
    logic [IDX_W:0]   count_next;

    logic [IDX_W-1:0]     lane_idx [2];
    logic [1:0]           ret;
    logic [1:0]           n_ret;
    sb_pkg::sb_inst_t     cand;
    logic                 fire;
    sb_pkg::sb_wb_t [1:0] wb;

    assign wb = {mul_wb_i, alu_wb_i};

    // in-order retire, lane 1 only behind lane 0
    assign lane_idx[0] = rptr_q;
    assign lane_idx[1] = rptr_q + 1'b1;
    assign ret[0] = valid_q[lane_idx[0]] & exec_q[lane_idx[0]];
    assign ret[1] = ret[0] & valid_q[lane_idx[1]] & exec_q[lane_idx[1]];
    assign n_ret = ret[1] ? 2'd2 : {1'b0, ret[0]};

    assign cand = inst_q[dptr_q];
    assign fire = valid_q[dptr_q] & ~disp_q[dptr_q] & ~fu_busy_i[cand.fu] & ~dest_busy_i;

    assign count_next = count_q + inst_valid_i - n_ret;

    always_comb begin
        disp_o.fire = fire;
        disp_o.tag = {1'b0, dptr_q};
        disp_o.inst = cand;
        for (int k = 0; k < 2; k++) begin
            retire_o[k].valid = ret[k];
            retire_o[k].id = inst_q[lane_idx[k]].id;
            retire_o[k].we = ret[k] && (inst_q[lane_idx[k]].rd != '0);  // r0 never written
            retire_o[k].rd = inst_q[lane_idx[k]].rd;
            retire_o[k].data = data_q[lane_idx[k]];
            retire_tag_o[k] = {1'b0, lane_idx[k]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            disp_q <= '0;
            exec_q <= '0;
            wptr_q <= '0;
            dptr_q <= '0;
            rptr_q <= '0;
            count_q <= '0;
            stall_o <= 1'b0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (ret[k]) begin
                    valid_q[lane_idx[k]] <= 1'b0;
                end
            end
            for (int u = 0; u < 2; u++) begin
                if (wb[u].valid) begin
                    exec_q[wb[u].tag[IDX_W-1:0]] <= 1'b1;
                end
            end
            if (fire) begin
                disp_q[dptr_q] <= 1'b1;
                dptr_q <= dptr_q + 1'b1;
            end
            if (inst_valid_i) begin
                valid_q[wptr_q] <= 1'b1;
                disp_q[wptr_q] <= 1'b0;
                exec_q[wptr_q] <= 1'b0;
                wptr_q <= wptr_q + 1'b1;
            end
            rptr_q <= rptr_q + n_ret;
            count_q <= count_next;
            stall_o <= (count_next > `SB_STALL_LEVEL);
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            inst_q[wptr_q] <= inst_i;
        end
        for (int u = 0; u < 2; u++) begin
            if (wb[u].valid) begin
                data_q[wb[u].tag[IDX_W-1:0]] <= wb[u].data;
            end
        end
    end

    a_no_strobe_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid_i |-> !stall_o);

    a_alu_wb_dispatched: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb_i.valid |-> disp_q[alu_wb_i.tag[IDX_W-1:0]]);

    a_mul_wb_dispatched: assert property (@(posedge clk) disable iff (!rst_n)
        mul_wb_i.valid |-> disp_q[mul_wb_i.tag[IDX_W-1:0]]);

endmodule

`default_nettype wire

//--- src/sb_reg_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_reg_status (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sb_pkg::sb_disp_t         disp_i,
    input  sb_pkg::sb_retire_t [1:0] retire_i,
    input  sb_pkg::sb_tag_t [1:0]    retire_tag_i,
    output logic                     dest_busy_o,
    output sb_pkg::sb_tag_t [1:0]    src_tags_o
);

    sb_pkg::sb_tag_t tag_q [`SB_NUM_REGS];
    sb_pkg::sb_tag_t dest_tag;
    sb_pkg::sb_reg_t rt;

    // a producer retiring this cycle counts as gone
    function automatic sb_pkg::sb_tag_t bypass(input sb_pkg::sb_tag_t t,
                                               input sb_pkg::sb_retire_t [1:0] ret,
                                               input sb_pkg::sb_tag_t [1:0] ret_tag);
        sb_pkg::sb_tag_t r;
        r = t;
        for (int k = 0; k < 2; k++) begin
            if (ret[k].valid && t == ret_tag[k]) begin
                r = sb_pkg::SB_TAG_NULL;
            end
        end
        return r;
    endfunction

    always_comb begin
        rt = disp_i.inst.use_imm ? '0 : disp_i.inst.src2.r.rt;  // imm reads as r0
        dest_tag = bypass(tag_q[disp_i.inst.rd], retire_i, retire_tag_i);
        dest_busy_o = !dest_tag[`SB_IDX_W];
        src_tags_o[0] = bypass(tag_q[disp_i.inst.rs], retire_i, retire_tag_i);
        src_tags_o[1] = bypass(tag_q[rt], retire_i, retire_tag_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SB_NUM_REGS; i++) begin
                tag_q[i] <= sb_pkg::SB_TAG_NULL;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (retire_i[k].valid && tag_q[retire_i[k].rd] == retire_tag_i[k]) begin
                    tag_q[retire_i[k].rd] <= sb_pkg::SB_TAG_NULL;
                end
            end
            // new producer wins over a clear
            if (disp_i.fire && disp_i.inst.rd != '0) begin
                tag_q[disp_i.inst.rd] <= disp_i.tag;
            end
        end
    end

    a_no_waw_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
        disp_i.fire |-> !dest_busy_o);

endmodule

`default_nettype wire

//--- src/sb_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sb_pkg::sb_retire_t [1:0]      retire_i,
    input  sb_pkg::sb_reg_t [3:0]         raddr_i,
    output logic [3:0][`SB_XLEN-1:0]      rdata_o
);

    logic [`SB_XLEN-1:0] mem_q [`SB_NUM_REGS];

    // architectural state starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SB_NUM_REGS; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (retire_i[k].we) begin
                    mem_q[retire_i[k].rd] <= retire_i[k].data;  // lane 1 last, younger
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : mem_q[raddr_i[p]];
        end
    end

endmodule

`default_nettype wire

//--- src/sb_fu_station.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_fu_station #(
    parameter sb_pkg::sb_fu_e UNIT = sb_pkg::FU_ALU
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sb_pkg::sb_disp_t              disp_i,
    input  sb_pkg::sb_tag_t [1:0]         src_tags_i,
    input  sb_pkg::sb_tag_t [1:0]         retire_tag_i,
    input  logic [1:0]                    retire_valid_i,
    input  logic [1:0][`SB_XLEN-1:0]      rdata_i,
    output sb_pkg::sb_reg_t [1:0]         raddr_o,
    output logic                          busy_o,
    output sb_pkg::sb_issue_t             issue_o
);

    logic busy_q;
    logic issued_q;
    logic load;
    logic own_retire;

    sb_pkg::sb_op_e         op_q;
    sb_pkg::sb_tag_t        tag_q;
    sb_pkg::sb_tag_t [1:0]  src_tag_q;
    sb_pkg::sb_reg_t [1:0]  src_reg_q;
    logic                   use_imm_q;
    logic [`SB_XLEN-1:0]    imm_q;

    assign load = disp_i.fire && (disp_i.inst.fu == UNIT);
    assign own_retire = |(retire_valid_i & {retire_tag_i[1] == tag_q, retire_tag_i[0] == tag_q});
    assign busy_o = busy_q;
    assign raddr_o = src_reg_q;

    always_comb begin
        issue_o.valid = busy_q && !issued_q
                        && src_tag_q[0][`SB_IDX_W] && src_tag_q[1][`SB_IDX_W];
        issue_o.tag = tag_q;
        issue_o.op = op_q;
        issue_o.a = rdata_i[0];
        issue_o.b = use_imm_q ? imm_q : rdata_i[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            issued_q <= 1'b0;
        end else if (load) begin
            busy_q <= 1'b1;
            issued_q <= 1'b0;
        end else begin
            if (own_retire) busy_q <= 1'b0;  // held until retire, no early reuse
            if (issue_o.valid) issued_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q <= disp_i.inst.op;
            tag_q <= disp_i.tag;
            use_imm_q <= disp_i.inst.use_imm;
            src_reg_q[0] <= disp_i.inst.rs;
            src_reg_q[1] <= disp_i.inst.use_imm ? '0 : disp_i.inst.src2.r.rt;
            imm_q <= {{(`SB_XLEN-16){disp_i.inst.src2.imm[15]}}, disp_i.inst.src2.imm};
            src_tag_q <= src_tags_i;
        end else begin
            // wakeup
            for (int j = 0; j < 2; j++) begin
                for (int k = 0; k < 2; k++) begin
                    if (retire_valid_i[k] && src_tag_q[j] == retire_tag_i[k]) begin
                        src_tag_q[j] <= sb_pkg::SB_TAG_NULL;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sb_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  sb_pkg::sb_issue_t issue_i,
    output sb_pkg::sb_wb_t    wb_o
);

    logic [`SB_XLEN-1:0] res;
    logic                valid_q;
    sb_pkg::sb_tag_t     tag_q;
    logic [`SB_XLEN-1:0] data_q;

    always_comb begin
        case (issue_i.op)
            sb_pkg::OP_ADD: res = issue_i.a + issue_i.b;
            sb_pkg::OP_SUB: res = issue_i.a - issue_i.b;
            sb_pkg::OP_AND: res = issue_i.a & issue_i.b;
            sb_pkg::OP_OR:  res = issue_i.a | issue_i.b;
            sb_pkg::OP_XOR: res = issue_i.a ^ issue_i.b;
            sb_pkg::OP_SLT: res = {{(`SB_XLEN-1){1'b0}}, $signed(issue_i.a) < $signed(issue_i.b)};
            default:        res = '0;  // mul goes elsewhere
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i.valid) begin
            tag_q <= issue_i.tag;
            data_q <= res;
        end
    end

    assign wb_o = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

//--- src/sb_mul_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_mul_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  sb_pkg::sb_issue_t issue_i,
    output sb_pkg::sb_wb_t    wb_o
);

    localparam int CNT_W = $clog2(`SB_MUL_LAT + 1);

    logic [CNT_W-1:0]      cnt_q;
    sb_pkg::sb_tag_t       tag_q;
    logic [`SB_XLEN-1:0]   a_q;
    logic [`SB_XLEN-1:0]   b_q;
    logic [2*`SB_XLEN-1:0] prod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (issue_i.valid) begin
            cnt_q <= CNT_W'(`SB_MUL_LAT);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i.valid) begin
            tag_q <= issue_i.tag;
            a_q <= issue_i.a;
            b_q <= issue_i.b;
        end
    end

    assign prod = a_q * b_q;

    // last count is the writeback cycle, low word only
    assign wb_o = '{valid: (cnt_q == CNT_W'(1)), tag: tag_q, data: prod[`SB_XLEN-1:0]};

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        issue_i.valid |-> cnt_q == '0);

endmodule

`default_nettype wire

//--- src/sb_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inst_valid_i,
    input  sb_pkg::sb_inst_t         inst_i,
    output logic                     stall_o,
    output sb_pkg::sb_retire_t [1:0] retire_o
);

    sb_pkg::sb_disp_t            disp;
    sb_pkg::sb_tag_t [1:0]       src_tags;
    sb_pkg::sb_tag_t [1:0]       retire_tag;
    sb_pkg::sb_issue_t           alu_issue;
    sb_pkg::sb_issue_t           mul_issue;
    sb_pkg::sb_wb_t              alu_wb;
    sb_pkg::sb_wb_t              mul_wb;
    sb_pkg::sb_reg_t [1:0]       alu_raddr;
    sb_pkg::sb_reg_t [1:0]       mul_raddr;
    logic [3:0][`SB_XLEN-1:0]    rdata;
    logic                        alu_busy;
    logic                        mul_busy;
    logic                        dest_busy;

    sb_window u_window (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .fu_busy_i    ({mul_busy, alu_busy}),  // indexed by sb_fu_e
        .dest_busy_i  (dest_busy),
        .alu_wb_i     (alu_wb),
        .mul_wb_i     (mul_wb),
        .stall_o      (stall_o),
        .disp_o       (disp),
        .retire_o     (retire_o),
        .retire_tag_o (retire_tag)
    );

    sb_reg_status u_reg_status (
        .clk          (clk),
        .rst_n        (rst_n),
        .disp_i       (disp),
        .retire_i     (retire_o),
        .retire_tag_i (retire_tag),
        .dest_busy_o  (dest_busy),
        .src_tags_o   (src_tags)
    );

    sb_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire_i (retire_o),
        .raddr_i  ({mul_raddr, alu_raddr}),
        .rdata_o  (rdata)
    );

    sb_fu_station #(.UNIT(sb_pkg::FU_ALU)) u_alu_station (
        .clk            (clk),
        .rst_n          (rst_n),
        .disp_i         (disp),
        .src_tags_i     (src_tags),
        .retire_tag_i   (retire_tag),
        .retire_valid_i ({retire_o[1].valid, retire_o[0].valid}),
        .rdata_i        (rdata[1:0]),
        .raddr_o        (alu_raddr),
        .busy_o         (alu_busy),
        .issue_o        (alu_issue)
    );

    sb_fu_station #(.UNIT(sb_pkg::FU_MUL)) u_mul_station (
        .clk            (clk),
        .rst_n          (rst_n),
        .disp_i         (disp),
        .src_tags_i     (src_tags),
        .retire_tag_i   (retire_tag),
        .retire_valid_i ({retire_o[1].valid, retire_o[0].valid}),
        .rdata_i        (rdata[3:2]),
        .raddr_o        (mul_raddr),
        .busy_o         (mul_busy),
        .issue_o        (mul_issue)
    );

    sb_alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue_i (alu_issue),
        .wb_o    (alu_wb)
    );

    sb_mul_timer u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue_i (mul_issue),
        .wb_o    (mul_wb)
    );

endmodule

`default_nettype wire

//--- dv/sb_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_settings.svh"

module sb_core_tb;

    localparam int PERIOD = 4;
    localparam int DRIVE_DLY = 1;
    localparam int N_INST = 400;
    localparam int N_BURST = 40;  // trailing back-to-back MULs
    localparam int WATCHDOG_NS = N_INST * (`SB_MUL_LAT + 8) * PERIOD;

    logic                     clk;
    logic                     rst_n;
    logic                     inst_valid_i;
    sb_pkg::sb_inst_t         inst_i;
    logic                     stall_o;
    sb_pkg::sb_retire_t [1:0] retire_o;

    integer seed = 70632;
    int     errors = 0;
    int     strobed = 0;
    int     retired = 0;
    bit     stall_seen = 0;

    logic [`SB_XLEN-1:0] model_rf [`SB_NUM_REGS];
    sb_pkg::sb_retire_t  exp_q [$];

    sb_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_o      (stall_o),
        .retire_o     (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [`SB_XLEN-1:0] read_model(input sb_pkg::sb_reg_t r);
        return (r == '0) ? '0 : model_rf[r];
    endfunction

    // registers r0-r3 only, so hazards are dense
    task automatic make_inst(input int idx, input bit force_mul, output sb_pkg::sb_inst_t inst);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  k;
        r = $random(seed);
        r2 = $random(seed);
        inst = '0;
        inst.id = idx[15:0];
        if (force_mul || r[2:0] < 3'd2) begin
            inst.fu = sb_pkg::FU_MUL;
            inst.op = sb_pkg::OP_MUL;
        end else begin
            k = 3'((r >> 3) % 6);
            inst.fu = sb_pkg::FU_ALU;
            inst.op = sb_pkg::sb_op_e'(k);
        end
        inst.rd = {3'b000, r[9:8]};
        inst.rs = {3'b000, r[11:10]};
        inst.use_imm = r[12];
        if (r[12]) begin
            if (r[15]) inst.src2.imm = r2[15:0];
            else inst.src2.imm = {{11{r2[4]}}, r2[4:0]};  // small signed value
        end else begin
            inst.src2.r.pad = '0;
            inst.src2.r.rt = {3'b000, r[14:13]};
        end
    endtask

    // sequential reference, one instruction at a time in strobe order
    task automatic model_exec(input sb_pkg::sb_inst_t inst);
        logic [`SB_XLEN-1:0]   a;
        logic [`SB_XLEN-1:0]   b;
        logic [`SB_XLEN-1:0]   res;
        logic [2*`SB_XLEN-1:0] prod;
        sb_pkg::sb_retire_t    e;
        a = read_model(inst.rs);
        if (inst.use_imm) b = {{(`SB_XLEN - 16){inst.src2.imm[15]}}, inst.src2.imm};
        else b = read_model(inst.src2.r.rt);
        prod = a * b;
        case (inst.op)
            sb_pkg::OP_ADD: res = a + b;
            sb_pkg::OP_SUB: res = a - b;
            sb_pkg::OP_AND: res = a & b;
            sb_pkg::OP_OR:  res = a | b;
            sb_pkg::OP_XOR: res = a ^ b;
            sb_pkg::OP_SLT: res = ($signed(a) < $signed(b)) ? 1 : 0;
            default:        res = prod[`SB_XLEN-1:0];
        endcase
        e.valid = 1'b1;
        e.id = inst.id;
        e.we = (inst.rd != '0);
        e.rd = inst.rd;
        e.data = res;
        if (e.we) model_rf[inst.rd] = res;
        exp_q.push_back(e);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_lane(input int k);
        sb_pkg::sb_retire_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("error at %0t ns: lane %0d retired with nothing outstanding", $time, k);
        end else begin
            e = exp_q.pop_front();
            compare_value($sformatf("retire_o[%0d].id", k), retire_o[k].id, e.id);
            compare_value($sformatf("retire_o[%0d].rd", k), retire_o[k].rd, e.rd);
            compare_value($sformatf("retire_o[%0d].we", k), retire_o[k].we, e.we);
            compare_value($sformatf("retire_o[%0d].data", k), retire_o[k].data, e.data);
            retired++;
        end
    endtask

    // retire, stall and occupancy monitor
    initial begin
        logic exp_stall;
        forever begin
            @(negedge clk);
            if (strobed == 0 && (stall_o !== 1'b0 || retire_o[0].valid !== 1'b0
                                 || retire_o[1].valid !== 1'b0)) begin
                errors++;
                $display("error at %0t ns: stall or retire active before the first strobe",
                         $time);
            end
            // window occupancy as of the last edge
            exp_stall = (strobed - int'(inst_valid_i) - retired) > `SB_STALL_LEVEL;
            compare_value("stall_o", stall_o, exp_stall);
            if (retire_o[1].valid && !retire_o[0].valid) begin
                errors++;
                $display("error at %0t ns: retire lane 1 valid without lane 0", $time);
            end
            if (retire_o[0].valid) check_lane(0);
            if (retire_o[0].valid && retire_o[1].valid) check_lane(1);
            if (strobed - retired > `SB_DEPTH) begin
                errors++;
                $display("error at %0t ns: %0d instructions outstanding, window holds %0d",
                         $time, strobed - retired, `SB_DEPTH);
            end
            if (stall_o && strobed >= N_INST - N_BURST) stall_seen = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: only %0d of %0d instructions retired", retired, N_INST);
        $display("Test failures found");
        $finish;
    end

    initial begin
        sb_pkg::sb_inst_t inst;
        logic [31:0]      gap;
        rst_n = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = '0;
        for (int i = 0; i < `SB_NUM_REGS; i++) model_rf[i] = '0;
        repeat (4) @(posedge clk);
        #(DRIVE_DLY) rst_n = 1'b1;
        while (strobed < N_INST) begin
            @(posedge clk);
            #(DRIVE_DLY);
            inst_valid_i = 1'b0;
            gap = $random(seed);
            if (!stall_o && (strobed >= N_INST - N_BURST || gap[1:0] != 2'b00)) begin
                make_inst(strobed, strobed >= N_INST - N_BURST, inst);
                model_exec(inst);
                inst_i = inst;
                inst_valid_i = 1'b1;
                strobed++;
            end
        end
        @(posedge clk);
        #(DRIVE_DLY) inst_valid_i = 1'b0;
        wait (retired == N_INST);
        repeat (8) @(posedge clk);  // catch stray retires
        if (!stall_seen) begin
            errors++;
            $display("stall_o never rose during the MUL burst");
        end
        $display("%0d errors, %0d of %0d instructions retired", errors, retired, N_INST);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sb_core.f
+incdir+src
src/sb_pkg.sv
src/sb_window.sv
src/sb_reg_status.sv
src/sb_regfile.sv
src/sb_fu_station.sv
src/sb_alu.sv
src/sb_mul_timer.sv
src/sb_core.sv
dv/sb_core_tb.sv
